//--- Bender.yml
package:
  name: hilbert_transform

sources:
  - include_dirs:
      - common
    files:
      - common/hilbertPkg.sv
      - hw/hilbertCoeffRom.sv
      - hilbertFir/hilbertFir.sv
      - hw/groupDelay.sv
      - hw/analyticCombiner.sv
      - hw/hilbertTransform.sv
  - target: test
    include_dirs:
      - common
    files:
      - test/tbClock.sv
      - test/hilbertTb.sv

//--- all.f
+incdir+common
common/hilbertPkg.sv
hw/hilbertCoeffRom.sv
hilbertFir/hilbertFir.sv
hw/groupDelay.sv
hw/analyticCombiner.sv
hw/hilbertTransform.sv
test/tbClock.sv
test/hilbertTb.sv

//--- common/hilbertPkg.sv
`default_nettype none

`include "hilbert_cfg.svh"

package hilbertPkg;

	// Group delay of the filter in samples, which is also the real path delay.
	localparam int GROUP_DELAY = (`HILBERT_TAPS - 1) / 2;

	localparam real PI = 3.14159265358979323846;

	// One signed real sample as it enters the transformer.
	typedef logic signed [`SAMPLE_WIDTH-1:0] sampleT;

	// One signed filter tap in fixed point with COEFF_FRAC fraction bits.
	typedef logic signed [`COEFF_WIDTH-1:0] coeffT;

	// One analytic output sample.
	// The real part is the delayed input and the imaginary part is the filter output.
	typedef struct packed {
		sampleT realPart;
		logic signed [`IMAG_WIDTH-1:0] imagPart;
	} analyticT;

	// Ideal Hilbert impulse response sampled at a tap index.
	// Taps at an even distance from the centre are zero.
	// The odd ones are 2/(pi*offset), scaled to fixed point and rounded to nearest.
	function automatic coeffT hilbertCoeff(input int unsigned tapIndex);
		int offset;
		real scaled;
		int rounded;
		offset = int'(tapIndex) - GROUP_DELAY;
		if (offset % 2 == 0) begin
			return '0;
		end
		scaled = 2.0 / (PI * real'(offset)) * (2.0 ** `COEFF_FRAC);
		// The cast from real rounds to the nearest integer.
		rounded = int'(scaled);
		return coeffT'(rounded);
	endfunction

endpackage

`default_nettype wire

//--- common/hilbert_cfg.svh
`ifndef HILBERT_CFG_SVH
`define HILBERT_CFG_SVH

// Number of filter taps.
// It must be odd so that the filter has a whole-sample group delay.
`define HILBERT_TAPS 27

// Width of the signed real input samples.
`define SAMPLE_WIDTH 16

// Signed coefficient width and the number of fraction bits in it.
`define COEFF_WIDTH 16
`define COEFF_FRAC 15

// Width of the imaginary output after the fraction bits are dropped.
// The tap magnitudes sum to about 2.5, so four spare bits leave headroom for any input.
`define IMAG_WIDTH (`SAMPLE_WIDTH + 4)

`endif

//--- hilbertFir/hilbertFir.sv
`timescale 1ns/1ps
`default_nettype none

`include "hilbert_cfg.svh"

module hilbertFir (
	input wire logic clock,
	input wire logic rstN,
	input wire logic coeffValid,
	input hilbertPkg::coeffT coeffData,
	input wire logic advance,
	input hilbertPkg::sampleT sampleIn,
	output logic coeffLoaded,
	output logic signed [`IMAG_WIDTH-1:0] imagPart
);

	localparam int TAPS = `HILBERT_TAPS;
	localparam int COUNT_WIDTH = $clog2(TAPS + 1);

	// Products of a sample and a tap, summed over every tap, with room for the growth.
	localparam int ACC_WIDTH = `SAMPLE_WIDTH + `COEFF_WIDTH + $clog2(TAPS);

	// Tap j of the bank multiplies the input from j samples ago.
	hilbertPkg::coeffT coeffBank [TAPS];

	// Window entry i holds the input from i+1 samples ago.
	// The current sample is not stored; it comes straight from sampleIn.
	hilbertPkg::sampleT window [TAPS-1];

	logic [COUNT_WIDTH-1:0] loadCount;
	logic signed [ACC_WIDTH-1:0] accumulated;
	logic signed [ACC_WIDTH-1:0] scaled;

	// Count the taps as they arrive.
	// Once all of them are in, the counter stops and the bank is frozen.
	always_ff @(posedge clock) begin
		if (!rstN) begin
			loadCount <= '0;
		end else if (coeffValid && !coeffLoaded) begin
			loadCount <= loadCount + 1'b1;
		end
	end

	assign coeffLoaded = (loadCount == TAPS);

	// The ROM sends tap 0 first, so each new tap enters at the top and the
	// older ones move down. After the last tap, entry j holds tap j.
	always_ff @(posedge clock) begin
		if (coeffValid && !coeffLoaded) begin
			coeffBank[TAPS-1] <= coeffData;
			for (int i = 0; i < TAPS - 1; i++) begin
				coeffBank[i] <= coeffBank[i+1];
			end
		end
	end

	// The sample window moves only on an accepted input.
	// Reset clears it, so the history before the first sample reads as zero.
	always_ff @(posedge clock) begin
		if (!rstN) begin
			window <= '{default: '0};
		end else if (advance) begin
			window[0] <= sampleIn;
			for (int i = 1; i < TAPS - 1; i++) begin
				window[i] <= window[i-1];
			end
		end
	end

	// Multiply-accumulate over the incoming sample and the stored window.
	// All operands are signed, so each product is sign extended to the accumulator.
	always_comb begin
		accumulated = coeffBank[0] * sampleIn;
		for (int j = 1; j < TAPS; j++) begin
			accumulated = accumulated + coeffBank[j] * window[j-1];
		end
	end

	// Drop the coefficient fraction bits.
	// The arithmetic shift rounds toward minus infinity.
	assign scaled = accumulated >>> `COEFF_FRAC;
	assign imagPart = scaled[`IMAG_WIDTH-1:0];

	// The combiner must hold off the input stream until the bank is full.
	advanceAfterLoad: assert property (
		@(posedge clock) disable iff (!rstN)
		advance |-> coeffLoaded
	) else $error("Sample accepted before the coefficient load finished.");

endmodule

`default_nettype wire

//--- hw/analyticCombiner.sv
`timescale 1ns/1ps
`default_nettype none

`include "hilbert_cfg.svh"

module analyticCombiner (
	input wire logic clock,
	input wire logic rstN,
	input wire logic coeffLoaded,
	input wire logic sampleValid,
	output logic sampleReady,
	input hilbertPkg::sampleT realPart,
	input wire logic signed [`IMAG_WIDTH-1:0] imagPart,
	output logic advance,
	output hilbertPkg::analyticT analyticOut,
	output logic outValid,
	input wire logic outReady
);

	// The input is taken only once the taps are in and the output slot is free
	// or being emptied in the same cycle.
	assign sampleReady = coeffLoaded && (!outValid || outReady);

	// An input transfer moves every stage by one sample.
	assign advance = sampleValid && sampleReady;

	// Output valid flag.
	// It drops only when the consumer takes the sample and nothing new arrives.
	always_ff @(posedge clock) begin
		if (!rstN) begin
			outValid <= 1'b0;
		end else if (advance) begin
			outValid <= 1'b1;
		end else if (outReady) begin
			outValid <= 1'b0;
		end
	end

	// Both parts belong to the same input sample, so they are captured together.
	always_ff @(posedge clock) begin
		if (advance) begin
			analyticOut.realPart <= realPart;
			analyticOut.imagPart <= imagPart;
		end
	end

	// A refused input sample must stay offered until it is taken.
	heldUntilTaken: assert property (
		@(posedge clock) disable iff (!rstN)
		(sampleValid && !sampleReady) |=> sampleValid
	) else $error("Input sample was withdrawn before it was accepted.");

endmodule

`default_nettype wire

//--- hw/groupDelay.sv
`timescale 1ns/1ps
`default_nettype none

module groupDelay (
	input wire logic clock,
	input wire logic rstN,
	input wire logic advance,
	input hilbertPkg::sampleT sampleIn,
	output hilbertPkg::sampleT realPart
);

	// The real path lags by the filter's group delay.
	localparam int DELAY = hilbertPkg::GROUP_DELAY;

	if (DELAY == 0) begin : genNoDelay

		// A single-tap filter has no delay, so the sample passes straight through.
		assign realPart = sampleIn;

	end else begin : genDelayLine

		// Entry i holds the input from i+1 accepted samples ago.
		hilbertPkg::sampleT delayLine [DELAY];

		// The line steps together with the filter window.
		// Reset fills it with zeros to match the filter history.
		always_ff @(posedge clock) begin
			if (!rstN) begin
				delayLine <= '{default: '0};
			end else if (advance) begin
				delayLine[0] <= sampleIn;
				for (int i = 1; i < DELAY; i++) begin
					delayLine[i] <= delayLine[i-1];
				end
			end
		end

		// The oldest entry lines up with the centre tap of the filter.
		assign realPart = delayLine[DELAY-1];

	end

endmodule

`default_nettype wire

//--- hw/hilbertCoeffRom.sv
`timescale 1ns/1ps
`default_nettype none

`include "hilbert_cfg.svh"

module hilbertCoeffRom (
	input wire logic clock,
	input wire logic rstN,
	output logic coeffValid,
	output hilbertPkg::coeffT coeffData
);

	localparam int TAPS = `HILBERT_TAPS;
	localparam int INDEX_WIDTH = $clog2(TAPS + 1);

	// Table of all tap values, fixed at elaboration.
	hilbertPkg::coeffT coeffTable [TAPS];

	logic [INDEX_WIDTH-1:0] tapIndex;
	logic finished;

	// Each entry is a constant, so the table folds into plain logic.
	for (genvar tapIdx = 0; tapIdx < TAPS; tapIdx++) begin : genTable
		localparam hilbertPkg::coeffT TAP_VALUE = hilbertPkg::hilbertCoeff(tapIdx);
		assign coeffTable[tapIdx] = TAP_VALUE;
	end

	// The index walks through the table once after reset, one tap per cycle.
	// When the last tap has gone out, the ROM parks and keeps coeffValid low.
	always_ff @(posedge clock) begin
		if (!rstN) begin
			tapIndex <= '0;
			finished <= 1'b0;
			coeffValid <= 1'b0;
		end else if (!finished) begin
			coeffValid <= 1'b1;
			if (tapIndex == TAPS - 1) begin
				finished <= 1'b1;
			end else begin
				tapIndex <= tapIndex + 1'b1;
			end
		end else begin
			coeffValid <= 1'b0;
		end
	end

	// The data register follows the index and needs no reset.
	always_ff @(posedge clock) begin
		if (!finished) begin
			coeffData <= coeffTable[tapIndex];
		end
	end

endmodule

`default_nettype wire

//--- hw/hilbertTransform.sv
`timescale 1ns/1ps
`default_nettype none

`include "hilbert_cfg.svh"

module hilbertTransform (
	input wire logic clock,
	input wire logic rstN,
	input hilbertPkg::sampleT sampleIn,
	input wire logic sampleValid,
	output logic sampleReady,
	output hilbertPkg::analyticT analyticOut,
	output logic outValid,
	input wire logic outReady
);

	// Tap stream from the ROM into the filter.
	logic coeffValid;
	hilbertPkg::coeffT coeffData;

	// Load status and the shared step signal.
	logic coeffLoaded;
	logic advance;

	// The two parts of the analytic sample before registration.
	hilbertPkg::sampleT realPart;
	logic signed [`IMAG_WIDTH-1:0] imagPart;

	hilbertCoeffRom coeffRom_i (
		.clock (clock),
		.rstN (rstN),
		.coeffValid (coeffValid),
		.coeffData (coeffData)
	);

	// Imaginary path.
	hilbertFir fir_i (
		.clock (clock),
		.rstN (rstN),
		.coeffValid (coeffValid),
		.coeffData (coeffData),
		.advance (advance),
		.sampleIn (sampleIn),
		.coeffLoaded (coeffLoaded),
		.imagPart (imagPart)
	);

	// Real path.
	groupDelay delay_i (
		.clock (clock),
		.rstN (rstN),
		.advance (advance),
		.sampleIn (sampleIn),
		.realPart (realPart)
	);

	analyticCombiner combiner_i (
		.clock (clock),
		.rstN (rstN),
		.coeffLoaded (coeffLoaded),
		.sampleValid (sampleValid),
		.sampleReady (sampleReady),
		.realPart (realPart),
		.imagPart (imagPart),
		.advance (advance),
		.analyticOut (analyticOut),
		.outValid (outValid),
		.outReady (outReady)
	);

endmodule

`default_nettype wire

//--- test/hilbertTb.sv
`timescale 1ns/1ps
`default_nettype none

`include "hilbert_cfg.svh"

module hilbertTb;

	localparam int TAPS = `HILBERT_TAPS;
	localparam int DELAY = hilbertPkg::GROUP_DELAY;
	localparam int STREAM_TIMEOUT = 5000;
	localparam int RESET_TIMEOUT = 50;
	localparam hilbertPkg::sampleT SAMPLE_MAX = {1'b0, {(`SAMPLE_WIDTH-1){1'b1}}};
	localparam hilbertPkg::sampleT SAMPLE_MIN = {1'b1, {(`SAMPLE_WIDTH-1){1'b0}}};

	logic clock;
	logic rstN;
	logic restart;
	hilbertPkg::sampleT sampleIn;
	logic sampleValid;
	logic sampleReady;
	hilbertPkg::analyticT analyticOut;
	logic outValid;
	logic outReady;

	// The reference model keeps the taps, the input history with the newest entry first,
	// and the pending outputs.
	hilbertPkg::coeffT coeffs [TAPS];
	hilbertPkg::sampleT history [TAPS];
	hilbertPkg::analyticT expectQueue [$];
	hilbertPkg::analyticT seenOut [$];
	hilbertPkg::sampleT sendQueue [$];
	logic [31:0] rngState;
	logic stallPending;
	logic lastInXfer;
	hilbertPkg::analyticT stalledOut;

	tbClock clockGen_i (.restart(restart), .clock(clock), .rstN(rstN));

	hilbertTransform dut_i (
		.clock (clock),
		.rstN (rstN),
		.sampleIn (sampleIn),
		.sampleValid (sampleValid),
		.sampleReady (sampleReady),
		.analyticOut (analyticOut),
		.outValid (outValid),
		.outReady (outReady)
	);

	task automatic failRun(input string reason);
		$display("%s", reason);
		$display("Verification failed");
		$fatal(1);
	endtask

	task automatic checkAnalytic(input string name, input hilbertPkg::analyticT got,
			input hilbertPkg::analyticT expected);
		if (got.realPart !== expected.realPart) begin
			$display("[ERROR] %s.realPart got %h expected %h", name, got.realPart,
				expected.realPart);
			failRun("Real part mismatch.");
		end
		if (got.imagPart !== expected.imagPart) begin
			$display("[ERROR] %s.imagPart got %h expected %h", name, got.imagPart,
				expected.imagPart);
			failRun("Imaginary part mismatch.");
		end
	endtask

	task automatic checkFlag(input string name, input logic got, input logic expected);
		if (got !== expected) begin
			$display("[ERROR] %s got %h expected %h", name, got, expected);
			failRun("Control flag mismatch.");
		end
	endtask

	// Xorshift generator with a 32-bit state.
	function automatic logic [31:0] nextRandom();
		rngState = rngState ^ (rngState << 13);
		rngState = rngState ^ (rngState >> 17);
		rngState = rngState ^ (rngState << 5);
		return rngState;
	endfunction

	function automatic hilbertPkg::sampleT randomSample();
		logic [31:0] r;
		r = nextRandom();
		return r[`SAMPLE_WIDTH-1:0];
	endfunction

	// Shift one accepted sample into the history and queue the output it must produce.
	// The imaginary sum is kept at full precision so that any wrap in the DUT shows up.
	task automatic acceptSample(input hilbertPkg::sampleT sample);
		longint acc;
		longint limit;
		hilbertPkg::analyticT result;
		for (int i = TAPS - 1; i > 0; i--) begin
			history[i] = history[i-1];
		end
		history[0] = sample;
		acc = 0;
		for (int j = 0; j < TAPS; j++) begin
			acc = acc + longint'(coeffs[j]) * longint'(history[j]);
		end
		acc = acc >>> `COEFF_FRAC;
		limit = longint'(1) <<< (`IMAG_WIDTH - 1);
		if (acc >= limit || acc < -limit) begin
			failRun("The expected imaginary part does not fit the output width.");
		end
		result.realPart = history[DELAY];
		result.imagPart = acc;
		expectQueue.push_back(result);
	endtask

	// One clock cycle. Outputs are sampled at the falling edge, where they are settled.
	// Transfers seen there take place at the following rising edge.
	task automatic clockStep();
		logic inXfer;
		logic outXfer;
		@(negedge clock);
		inXfer = sampleValid && sampleReady;
		outXfer = outValid && outReady;
		if (stallPending) begin
			checkFlag("outValid", outValid, 1'b1);
			checkAnalytic("analyticOut", analyticOut, stalledOut);
		end
		stallPending = outValid && !outReady;
		stalledOut = analyticOut;
		if (outXfer) begin
			if (expectQueue.size() == 0) begin
				failRun("An output was delivered with no matching input sample.");
			end else begin
				checkAnalytic("analyticOut", analyticOut, expectQueue.pop_front());
				seenOut.push_back(analyticOut);
			end
		end
		if (inXfer) begin
			acceptSample(sampleIn);
		end
		lastInXfer = inXfer;
		@(posedge clock);
		#1;
	endtask

	// Sends every queued sample and drains every expected output.
	// A sample stays valid and unchanged until it is accepted.
	task automatic runStream(input bit randomReady, input bit randomGaps);
		int cycles;
		logic [31:0] r;
		hilbertPkg::sampleT discard;
		cycles = 0;
		while (sendQueue.size() > 0 || expectQueue.size() > 0) begin
			if (!sampleValid && sendQueue.size() > 0) begin
				r = nextRandom();
				if (!randomGaps || r[1:0] != 2'b00) begin
					sampleValid = 1'b1;
					sampleIn = sendQueue[0];
				end
			end
			r = nextRandom();
			outReady = randomReady ? r[0] : 1'b1;
			clockStep();
			if (lastInXfer) begin
				discard = sendQueue.pop_front();
				sampleValid = 1'b0;
			end
			cycles++;
			if (cycles > STREAM_TIMEOUT) begin
				failRun("The stream did not drain before the timeout.");
			end
		end
	endtask

	// Waits until the reset line reaches a level and leaves 1 ns after the next rising edge.
	task automatic waitForReset(input logic level);
		int cycles;
		cycles = 0;
		do begin
			@(negedge clock);
			cycles++;
			if (cycles > RESET_TIMEOUT) begin
				failRun("The reset line did not reach the awaited level in time.");
			end
		end while (rstN !== level);
		@(posedge clock);
		#1;
	endtask

	// After reset is released, each tap needs a cycle of its own and the filter one more
	// cycle to count the last tap before input opens.
	task automatic checkCoeffLoad();
		int edges;
		waitForReset(1'b1);
		edges = 1;
		forever begin
			@(negedge clock);
			checkFlag("outValid", outValid, 1'b0);
			if (sampleReady === 1'b1) begin
				break;
			end
			edges++;
			if (edges > 4 * TAPS) begin
				failRun("sampleReady never rose after the coefficient load.");
			end
			@(posedge clock);
			#1;
		end
		if (edges <= TAPS) begin
			failRun("sampleReady rose before every tap could be loaded.");
		end
		@(posedge clock);
		#1;
	endtask

	// An impulse must reproduce the scaled taps on the imaginary part
	// and the impulse on the real part.
	task automatic impulseTest();
		hilbertPkg::analyticT expected;
		seenOut.delete();
		sendQueue.push_back(SAMPLE_MAX);
		for (int i = 0; i < TAPS + 2; i++) begin
			sendQueue.push_back('0);
		end
		runStream(1'b0, 1'b0);
		for (int k = 0; k < TAPS; k++) begin
			expected.realPart = (k == DELAY) ? SAMPLE_MAX : '0;
			expected.imagPart = (longint'(coeffs[k]) * longint'(SAMPLE_MAX)) >>> `COEFF_FRAC;
			checkAnalytic("impulse", seenOut[k], expected);
		end
	endtask

	task automatic randomStreamTest(input int count, input bit pressure);
		for (int i = 0; i < count; i++) begin
			sendQueue.push_back(randomSample());
		end
		runStream(pressure, pressure);
	endtask

	// Alternating extremes, then long runs at each end of the range to reach the largest sums.
	task automatic extremesTest();
		for (int i = 0; i < 60; i++) begin
			sendQueue.push_back((i % 2 == 0) ? SAMPLE_MIN : SAMPLE_MAX);
		end
		for (int i = 0; i < 2 * TAPS; i++) begin
			sendQueue.push_back((i < TAPS) ? SAMPLE_MIN : SAMPLE_MAX);
		end
		runStream(1'b0, 1'b0);
	endtask

	// Leaves an output stalled, resets mid-stream and restarts the model from zero history.
	task automatic midStreamReset();
		outReady = 1'b0;
		sampleValid = 1'b1;
		sampleIn = randomSample();
		clockStep();
		sampleValid = 1'b0;
		clockStep();
		checkFlag("outValid", outValid, 1'b1);
		restart = 1'b1;
		@(posedge clock);
		#1;
		restart = 1'b0;
		waitForReset(1'b0);
		@(negedge clock);
		checkFlag("outValid", outValid, 1'b0);
		checkFlag("sampleReady", sampleReady, 1'b0);
		for (int i = 0; i < TAPS; i++) begin
			history[i] = '0;
		end
		expectQueue.delete();
		stallPending = 1'b0;
		checkCoeffLoad();
		randomStreamTest(100, 1'b1);
	endtask

	initial begin
		sampleIn = '0;
		sampleValid = 1'b0;
		outReady = 1'b0;
		restart = 1'b0;
		rngState = 32'h4f7ca380;
		stallPending = 1'b0;
		lastInXfer = 1'b0;
		for (int i = 0; i < TAPS; i++) begin
			coeffs[i] = hilbertPkg::hilbertCoeff(i);
			history[i] = '0;
		end
		checkCoeffLoad();
		impulseTest();
		randomStreamTest(200, 1'b0);
		randomStreamTest(150, 1'b1);
		extremesTest();
		midStreamReset();
		$display("Verification passed");
		$finish;
	end

endmodule

`default_nettype wire

//--- test/tbClock.sv
`timescale 1ns/1ps
`default_nettype none

module tbClock (
	input wire logic restart,
	output logic clock,
	output logic rstN
);

	localparam int RESET_CYCLES = 8;

	// A 40 ns period.
	initial clock = 1'b0;
	always #20 clock = ~clock;

	// Reset is held low for eight rising edges at power-up and again after every restart request.
	// It changes 1 ns after an edge like every other stimulus.
	initial begin
		rstN = 1'b0;
		forever begin
			repeat (RESET_CYCLES) @(posedge clock);
			#1 rstN = 1'b1;
			do @(posedge clock); while (!restart);
			#1 rstN = 1'b0;
		end
	end

endmodule

`default_nettype wire
